/* common/led_panel_pkg.sv */
package led_panel_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Driver chain geometry
  ////////////////////////////////////////////////////////////////////////////

  // Parallel data lanes into the driver chain
  localparam int NUM_LANES = 30;

  // Grayscale or configuration payload
  localparam int WORD_BITS = 16;

  // Mode bit followed by the payload
  localparam int SHIFT_BITS = WORD_BITS + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Frame and PWM timing
  ////////////////////////////////////////////////////////////////////////////

  // Grayscale words between two blanking gaps
  localparam int WORDS_PER_FRAME = 4;

  // clock_33 cycles with gclk held low after a frame
  localparam int BLANKING_CYCLES = 80;

  // Driver configuration payload
  localparam logic [WORD_BITS-1:0] CONF_WORD = 16'hA5C3;

  ////////////////////////////////////////////////////////////////////////////
  // Shift payload types
  ////////////////////////////////////////////////////////////////////////////

  // What one lane receives per latch
  // mode is 1 for configuration, 0 for grayscale
  typedef struct packed {
    logic                 mode;
    logic [WORD_BITS-1:0] payload;
  } lane_word_t;

  // Full content of one shift, one entry per lane
  typedef struct packed {
    lane_word_t [NUM_LANES-1:0] lanes;
  } word_req_t;

endpackage

/* framebuffer/framebuffer_emulator.sv */
`timescale 1ns/100ps

module framebuffer_emulator (
  input  logic                                clock_33,
  input  logic                                nrst,
  input  logic                                word_take,
  output logic [led_panel_pkg::WORD_BITS-1:0] fb_word,
  output logic [7:0]                          fb_frame
);

  import led_panel_pkg::*;

  localparam int IDX_BITS = $clog2(WORDS_PER_FRAME);

  logic [IDX_BITS-1:0] word_idx;
  logic                last_idx;

  assign last_idx = (word_idx == IDX_BITS'(WORDS_PER_FRAME - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Word index and frame counter
  ////////////////////////////////////////////////////////////////////////////

  // A take moves to the next word in the following cycle
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      word_idx <= '0;
      fb_frame <= '0;
    end else if (word_take) begin
      if (last_idx) begin
        word_idx <= '0;
        fb_frame <= fb_frame + 8'd1;
      end else begin
        word_idx <= word_idx + 1'b1;
      end
    end
  end

  // Frame number in the high byte and word index in the low byte
  assign fb_word = {fb_frame, 8'(word_idx)};

endmodule

/* driver/conf_loader.sv */
`timescale 1ns/100ps

module conf_loader (
  input  logic                     clock_33,
  input  logic                     nrst,
  input  logic                     conf_reload,
  input  logic                     conf_done,
  output logic                     conf_req,
  output led_panel_pkg::word_req_t conf_word
);

  import led_panel_pkg::*;

  // Low only in the first cycle after reset release
  logic started;

  // conf_req is the pending flag itself
  // A reload in the done cycle wins over the clear, so it is not lost.
  // An earlier reload is covered by the shift still in progress,
  // since the configuration content never changes
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      started  <= 1'b0;
      conf_req <= 1'b0;
    end else begin
      started <= 1'b1;
      if (!started || conf_reload) begin
        conf_req <= 1'b1;
      end else if (conf_done) begin
        conf_req <= 1'b0;
      end
    end
  end

  // Same configuration on every lane
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      conf_word.lanes[k].mode    = 1'b1;
      conf_word.lanes[k].payload = CONF_WORD;
    end
  end

  // Arbiter may only finish a request that is still raised
  a_done_with_req: assert property (
    @(posedge clock_33) disable iff (!nrst) conf_done |-> conf_req)
    else $error("conf_done without conf_req");

endmodule

/* driver/gray_feeder.sv */
`timescale 1ns/100ps

module gray_feeder (
  input  logic                                clock_33,
  input  logic                                nrst,
  input  logic [led_panel_pkg::WORD_BITS-1:0] fb_word,
  input  logic                                gray_done,
  input  logic                                blank_end,
  output logic                                word_take,
  output logic                                gray_req,
  output led_panel_pkg::word_req_t            gray_word,
  output logic                                blank_start
);

  import led_panel_pkg::*;

  localparam int CNT_BITS = $clog2(WORDS_PER_FRAME);

  logic [CNT_BITS-1:0] word_cnt;
  logic                last_word;
  logic                blanking;
  logic                running;

  assign last_word = (word_cnt == CNT_BITS'(WORDS_PER_FRAME - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Request sequencing
  ////////////////////////////////////////////////////////////////////////////

  // Done in D drops the request and takes a word in D+1
  // The new word is requested in D+2
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      running     <= 1'b0;
      gray_req    <= 1'b0;
      word_take   <= 1'b0;
      blank_start <= 1'b0;
      blanking    <= 1'b0;
      word_cnt    <= '0;
    end else begin
      running     <= 1'b1;
      word_take   <= gray_done;
      blank_start <= gray_done && last_word;
      if (gray_done) begin
        gray_req <= 1'b0;
        if (last_word) begin
          word_cnt <= '0;
          blanking <= 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end else if (blank_end) begin
        // Next frame's first word is already fetched
        blanking <= 1'b0;
        gray_req <= 1'b1;
      end else if (!running || (word_take && !blanking)) begin
        gray_req <= 1'b1;
      end
    end
  end

  // Lane k gets the word XOR its lane number
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      gray_word.lanes[k].mode    = 1'b0;
      gray_word.lanes[k].payload = fb_word ^ WORD_BITS'(k);
    end
  end

  // The gclk gap may only end while the feeder waits for it
  a_end_in_gap: assert property (
    @(posedge clock_33) disable iff (!nrst) blank_end |-> blanking)
    else $error("blank_end while not blanking");

endmodule

/* driver/shift_arbiter.sv */
`timescale 1ns/100ps

module shift_arbiter (
  input  logic                                clock_33,
  input  logic                                nrst,
  input  logic                                conf_req,
  input  logic                                gray_req,
  input  led_panel_pkg::word_req_t            conf_word,
  input  led_panel_pkg::word_req_t            gray_word,
  output logic                                conf_done,
  output logic                                gray_done,
  output logic                                sclk,
  output logic                                lat,
  output logic [led_panel_pkg::NUM_LANES-1:0] sin
);

  import led_panel_pkg::*;

  localparam int BIT_BITS = $clog2(SHIFT_BITS);

  word_req_t           shift_q;
  word_req_t           grant_word;
  logic                busy;
  logic                owner_conf;
  logic [BIT_BITS-1:0] bit_cnt;
  logic                phase;
  logic                grant_conf;
  logic                grant_gray;
  logic                grant;
  logic                advance;
  logic                last_bit;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed priority grant
  ////////////////////////////////////////////////////////////////////////////

  // Owner still holds its request in the done cycle and is masked out
  assign grant_conf = !busy && conf_req && !conf_done;
  assign grant_gray = !busy && !grant_conf && gray_req && !gray_done;
  assign grant      = grant_conf || grant_gray;
  assign grant_word = grant_conf ? conf_word : gray_word;

  // End of the high phase of a bit
  assign advance  = busy && !lat && phase && (bit_cnt != '0);
  assign last_bit = busy && !lat && phase && (bit_cnt == '0);

  // Payload store shifted MSB first on each lane
  always_ff @(posedge clock_33) begin
    if (grant) begin
      shift_q <= grant_word;
    end else if (advance) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        shift_q.lanes[k] <= {shift_q.lanes[k][SHIFT_BITS-2:0], 1'b0};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bit and phase sequencer
  ////////////////////////////////////////////////////////////////////////////

  // Grant in G then bits in G+1 to G+34, lat in G+35 and done in G+36
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      busy       <= 1'b0;
      owner_conf <= 1'b0;
      bit_cnt    <= '0;
      phase      <= 1'b0;
      sclk       <= 1'b0;
      lat        <= 1'b0;
      sin        <= '0;
      conf_done  <= 1'b0;
      gray_done  <= 1'b0;
    end else begin
      conf_done <= 1'b0;
      gray_done <= 1'b0;
      if (grant) begin
        busy       <= 1'b1;
        owner_conf <= grant_conf;
        bit_cnt    <= BIT_BITS'(SHIFT_BITS - 1);
        phase      <= 1'b0;
        sclk       <= 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
          sin[k] <= grant_word.lanes[k].mode;
        end
      end else if (lat) begin
        lat       <= 1'b0;
        busy      <= 1'b0;
        conf_done <= owner_conf;
        gray_done <= !owner_conf;
      end else if (last_bit) begin
        lat  <= 1'b1;
        sclk <= 1'b0;
        sin  <= '0;
      end else if (advance) begin
        bit_cnt <= bit_cnt - 1'b1;
        phase   <= 1'b0;
        sclk    <= 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
          sin[k] <= shift_q.lanes[k][SHIFT_BITS-2];
        end
      end else if (busy) begin
        // Drivers sample sin on the rising edge of sclk
        phase <= 1'b1;
        sclk  <= 1'b1;
      end
    end
  end

  // Owner keeps its request up for the whole shift
  a_req_held: assert property (
    @(posedge clock_33) disable iff (!nrst)
      busy |-> (owner_conf ? conf_req : gray_req))
    else $error("request dropped before done");

  // Grayscale word stays put under its own shift
  a_word_held: assert property (
    @(posedge clock_33) disable iff (!nrst)
      (busy && !owner_conf) |-> $stable(gray_word))
    else $error("gray_word changed before done");

endmodule

/* driver/gclk_generator.sv */
`timescale 1ns/100ps

module gclk_generator (
  input  logic clock_33,
  input  logic nrst,
  input  logic blank_start,
  output logic gclk,
  output logic blank_end
);

  import led_panel_pkg::*;

  localparam int CNT_BITS = $clog2(BLANKING_CYCLES + 1);

  // Cycles of the gap still to run, zero when not blanking
  logic [CNT_BITS-1:0] blank_cnt;
  logic                blanking;

  assign blanking  = (blank_cnt != '0);
  assign blank_end = (blank_cnt == CNT_BITS'(1));

  ////////////////////////////////////////////////////////////////////////////
  // PWM clock with blanking gap
  ////////////////////////////////////////////////////////////////////////////

  // gclk low from the cycle after blank_start for BLANKING_CYCLES cycles
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      gclk      <= 1'b0;
      blank_cnt <= '0;
    end else if (blank_start) begin
      gclk      <= 1'b0;
      blank_cnt <= CNT_BITS'(BLANKING_CYCLES);
    end else begin
      if (blanking) begin
        blank_cnt <= blank_cnt - 1'b1;
      end
      // Last gap cycle resumes toggling
      gclk <= (blanking && !blank_end) ? 1'b0 : ~gclk;
    end
  end

  // Feeder must wait for blank_end before the next frame
  a_no_restart: assert property (
    @(posedge clock_33) disable iff (!nrst) blank_start |-> !blanking)
    else $error("blank_start during blanking");

endmodule

/* design/led_panel_top.sv */
`timescale 1ns/100ps

module led_panel_top (
  input  logic                                clock_33,
  input  logic                                nrst,
  input  logic                                conf_reload,
  output logic                                sclk,
  output logic                                lat,
  output logic                                gclk,
  output logic [led_panel_pkg::NUM_LANES-1:0] sin
);

  import led_panel_pkg::*;

  logic [WORD_BITS-1:0] fb_word;
  logic                 word_take;
  logic                 conf_req;
  logic                 conf_done;
  word_req_t            conf_word;
  logic                 gray_req;
  logic                 gray_done;
  word_req_t            gray_word;
  logic                 blank_start;
  logic                 blank_end;

  framebuffer_emulator framebuffer_emulator_i (
    .clock_33  (clock_33),
    .nrst      (nrst),
    .word_take (word_take),
    .fb_word   (fb_word),
    .fb_frame  ()
  );

  conf_loader conf_loader_i (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .conf_reload (conf_reload),
    .conf_done   (conf_done),
    .conf_req    (conf_req),
    .conf_word   (conf_word)
  );

  gray_feeder gray_feeder_i (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .fb_word     (fb_word),
    .gray_done   (gray_done),
    .blank_end   (blank_end),
    .word_take   (word_take),
    .gray_req    (gray_req),
    .gray_word   (gray_word),
    .blank_start (blank_start)
  );

  // Single serial port shared by configuration and grayscale
  shift_arbiter shift_arbiter_i (
    .clock_33  (clock_33),
    .nrst      (nrst),
    .conf_req  (conf_req),
    .gray_req  (gray_req),
    .conf_word (conf_word),
    .gray_word (gray_word),
    .conf_done (conf_done),
    .gray_done (gray_done),
    .sclk      (sclk),
    .lat       (lat),
    .sin       (sin)
  );

  gclk_generator gclk_generator_i (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .blank_start (blank_start),
    .gclk        (gclk),
    .blank_end   (blank_end)
  );

endmodule

/* bench/led_panel_tb.sv */
`timescale 1ns/100ps

module led_panel_tb;

  import led_panel_pkg::*;

  // Gap runs from the third cycle after the last word's latch
  localparam int GAP_FIRST = 3;
  localparam int GAP_LAST  = GAP_FIRST + BLANKING_CYCLES - 1;
  localparam int RUN_FRAMES = 10;
  // 12 frames, each word up to 40 cycles, two reloads per frame, plus margin
  localparam int WATCHDOG_CYCLES =
    12 * (WORDS_PER_FRAME * 40 + BLANKING_CYCLES + GAP_FIRST + 2 * 40) + 200;

  logic                 clock_33;
  logic                 nrst;
  logic                 conf_reload;
  logic                 sclk;
  logic                 lat;
  logic                 gclk;
  logic [NUM_LANES-1:0] sin;

  // Monitor state
  logic [NUM_LANES-1:0][SHIFT_BITS-1:0] rx_lanes;
  logic [NUM_LANES-1:0][SHIFT_BITS-1:0] conf_exp;
  logic [NUM_LANES-1:0][SHIFT_BITS-1:0] gray_exp;
  logic        sclk_d;
  logic        gclk_d;
  logic        nrst_d;
  logic        sclk_rise;
  logic        in_gap;
  logic [7:0]  model_frame;
  int          model_idx;
  int          rise_cnt;
  int          lat_count;
  int          cycle_cnt;
  int          gap_pos;
  int          latches_since;
  logic        reload_pending;
  integer      seed;
  int          lat_wait;
  int          delay;

  led_panel_top led_panel_top_i (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .conf_reload (conf_reload),
    .sclk        (sclk),
    .lat         (lat),
    .gclk        (gclk),
    .sin         (sin)
  );

  initial begin
    clock_33 = 1'b0;
    forever #50 clock_33 = ~clock_33;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopping on first error");
  endtask

  // Count latches, sampled mid-cycle
  task automatic wait_latches(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clock_33);
      #10;
      if (lat) seen++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  assign sclk_rise = sclk && !sclk_d;
  assign in_gap    = (gap_pos >= GAP_FIRST) && (gap_pos <= GAP_LAST);

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      conf_exp[k] = {1'b1, CONF_WORD};
      gray_exp[k] = {1'b0, {model_frame, 8'(model_idx)} ^ WORD_BITS'(k)};
    end
  end

  always @(posedge clock_33) begin
    cycle_cnt <= cycle_cnt + 1;
    sclk_d    <= sclk;
    gclk_d    <= gclk;
    nrst_d    <= nrst;
    if (!nrst) begin
      model_frame    <= '0;
      model_idx      <= 0;
      rise_cnt       <= 0;
      lat_count      <= 0;
      gap_pos        <= 0;
      latches_since  <= 0;
      reload_pending <= 1'b0;
    end else begin
      if (sclk_rise) begin
        for (int k = 0; k < NUM_LANES; k++) begin
          rx_lanes[k] <= {rx_lanes[k][SHIFT_BITS-2:0], sin[k]};
        end
        rise_cnt <= rise_cnt + 1;
      end
      if (gap_pos != 0) begin
        gap_pos <= (gap_pos == GAP_LAST + 1) ? 0 : gap_pos + 1;
      end
      if (lat) begin
        lat_count <= lat_count + 1;
        rise_cnt  <= 0;
        if (rx_lanes[0][SHIFT_BITS-1]) begin
          // Configuration latch serves any reload seen so far
          reload_pending <= 1'b0;
          latches_since  <= 0;
        end else begin
          if (model_idx == WORDS_PER_FRAME - 1) begin
            model_idx   <= 0;
            model_frame <= model_frame + 8'd1;
            gap_pos     <= 1;
          end else begin
            model_idx <= model_idx + 1;
          end
          if (reload_pending) latches_since <= latches_since + 1;
        end
      end
      if (conf_reload && !(lat && rx_lanes[0][SHIFT_BITS-1])) begin
        reload_pending <= 1'b1;
        latches_since  <= 0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clock_33)
    (!nrst && cycle_cnt >= 1) |-> (!sclk && !lat && !gclk && sin == '0))
    else report_error("outputs not idle during reset");

  a_first_conf: assert property (@(posedge clock_33) disable iff (!nrst)
    (lat && lat_count == 0) |-> rx_lanes == conf_exp)
    else report_error("first latch is not the configuration word");

  a_conf_content: assert property (@(posedge clock_33) disable iff (!nrst)
    (lat && rx_lanes[0][SHIFT_BITS-1]) |-> rx_lanes == conf_exp)
    else report_error("wrong configuration word");

  a_conf_wanted: assert property (@(posedge clock_33) disable iff (!nrst)
    (lat && rx_lanes[0][SHIFT_BITS-1]) |-> (lat_count == 0 || reload_pending))
    else report_error("configuration word without a reload");

  a_gray_content: assert property (@(posedge clock_33) disable iff (!nrst)
    (lat && !rx_lanes[0][SHIFT_BITS-1]) |-> rx_lanes == gray_exp)
    else report_error("wrong grayscale word");

  a_reload_served: assert property (@(posedge clock_33) disable iff (!nrst)
    (lat && !rx_lanes[0][SHIFT_BITS-1]) |-> !(reload_pending && latches_since >= 1))
    else report_error("reload not served by the second latch");

  a_rise_count: assert property (@(posedge clock_33) disable iff (!nrst)
    lat |-> rise_cnt == SHIFT_BITS)
    else report_error("wrong number of sclk edges before lat");

  a_lat_single: assert property (@(posedge clock_33) disable iff (!nrst)
    lat |=> !lat)
    else report_error("lat longer than one cycle");

  a_lat_sclk_low: assert property (@(posedge clock_33) disable iff (!nrst)
    lat |-> !sclk)
    else report_error("sclk high during lat");

  a_gap_low: assert property (@(posedge clock_33) disable iff (!nrst)
    in_gap |-> !gclk)
    else report_error("gclk high inside the blanking gap");

  a_gclk_toggle: assert property (@(posedge clock_33) disable iff (!nrst)
    (nrst_d && !in_gap) |-> gclk != gclk_d)
    else report_error("gclk did not toggle outside the gap");

  // Only a configuration shift may use the port during the gap
  a_gap_no_shift: assert property (@(posedge clock_33) disable iff (!nrst)
    (in_gap && sclk_rise) |-> reload_pending)
    else report_error("grayscale shift during the blanking gap");

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed        = 32'h57fc_244b;
    nrst        = 1'b0;
    conf_reload = 1'b0;
    cycle_cnt   = 0;
    repeat (8) @(posedge clock_33);
    #10 nrst = 1'b1;
    wait_latches(1);
    while (model_frame < 8'(RUN_FRAMES)) begin
      lat_wait = ($unsigned($random(seed)) % 8) + 1;
      delay    = $unsigned($random(seed)) % 40;
      wait_latches(lat_wait);
      repeat (delay) @(posedge clock_33);
      @(posedge clock_33);
      #10 conf_reload = 1'b1;
      @(posedge clock_33);
      #10 conf_reload = 1'b0;
    end
    wait_latches(3);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock_33);
    $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* build.f */
common/led_panel_pkg.sv
framebuffer/framebuffer_emulator.sv
driver/conf_loader.sv
driver/gray_feeder.sv
driver/shift_arbiter.sv
driver/gclk_generator.sv
design/led_panel_top.sv
bench/led_panel_tb.sv
